// ==== src/proc_cmd_pkg.sv ====
// Command-side types shared by the parser, the access stage and the transmitter
// Opcode values follow the external link protocol, anything unlisted is invalid
// Only one command is in flight, so no struct carries a tag
package proc_cmd_pkg;

    localparam int BYTE_W   = 8;  // Link byte width, both directions
    localparam int MAX_OPDS = 2;  // Address then data

    // ----------------------------------------
    // Opcodes
    // ----------------------------------------
    typedef enum logic [BYTE_W-1:0] {
        NOP         = 8'h00,  // Reserved, rejected like an unknown code
        INTERREGW   = 8'h01,
        INTERREGR   = 8'h02,
        GLOBALREGW  = 8'h03,
        GLOBALREGR  = 8'h04,
        JPEGREGW    = 8'h05,
        JPEGREGR    = 8'h06,
        DISPLAYREGW = 8'h07,
        DISPLAYREGR = 8'h08,
        SENSREGW    = 8'h09,
        SENSREGR    = 8'h0A,
        GETMEASNUM  = 8'h0B,
        GETMEAS     = 8'h0C,
        RTMEAS      = 8'h0D
    } opcode_t;

    typedef enum logic [1:0] {IDLE, GET_OPC, GET_OPDS, WAIT_ACK} parse_state_t;

    typedef enum logic [1:0] {READ_OK, WRITE_OK, TIMEOUT} ack_kind_t;

    // Parser to access stage
    typedef struct packed {
        opcode_t           opcode;
        logic [BYTE_W-1:0] addr;  // First operand
        logic [BYTE_W-1:0] data;  // Second operand, writes only
    } cmd_t;

    // Access stage to transmitter
    typedef struct packed {
        ack_kind_t         kind;
        logic [BYTE_W-1:0] read_data;
    } result_t;

endpackage

// ==== src/proc_reg_pkg.sv ====
// Register-side types for the special port and the shared register bus
// Bus address is a 2-bit block select above the 8-bit register address
// One response struct serves both ports
package proc_reg_pkg;

    localparam int REG_W      = 8;
    localparam int BUS_ADDR_W = 10;
    localparam int BLK_W      = BUS_ADDR_W - REG_W;

    // ----------------------------------------
    // Bus block offsets
    // ----------------------------------------
    localparam logic [BLK_W-1:0] B_GLOBAL  = 2'd0;
    localparam logic [BLK_W-1:0] B_JPEG    = 2'd1;
    localparam logic [BLK_W-1:0] B_DISPLAY = 2'd2;
    localparam logic [BLK_W-1:0] B_SENS    = 2'd3;

    // Fixed registers inside the sensor block
    localparam logic [REG_W-1:0] A_NMEAS   = 8'hF0;  // Measurement count
    localparam logic [REG_W-1:0] A_GETMEAS = 8'hF1;  // Live measurement

    typedef struct packed {
        logic             write_en;
        logic             read_en;
        logic [REG_W-1:0] addr;
        logic [REG_W-1:0] write_data;
    } spec_req_t;

    typedef struct packed {
        logic                  write_en;
        logic                  read_en;
        logic [BUS_ADDR_W-1:0] addr;
        logic [REG_W-1:0]      write_data;
    } bus_req_t;

    typedef struct packed {
        logic             data_ready;  // Read data valid, one cycle
        logic             write_done;  // Write taken, one cycle
        logic [REG_W-1:0] read_data;
    } reg_rsp_t;

endpackage

// ==== src/cmd_parser.sv ====
// Fetches an opcode and its operands one byte at a time from the receiver
// The receiver must hold data_byte valid in the data_ready cycle
// Incomplete commands are dropped after opds_time_count idle cycles
// No new byte is requested until the acknowledgement has been sent
module cmd_parser
    import proc_cmd_pkg::*;
#(
    parameter int TIME_W = 24
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              data_valid,
    input  logic              data_ready,
    input  logic [BYTE_W-1:0] data_byte,
    output logic              get_data,
    input  logic [TIME_W-1:0] opds_time_count,
    input  logic              ack_done,
    output cmd_t              cmd,
    output logic              cmd_valid
);

    localparam int CNT_W = $clog2(MAX_OPDS + 1);

    parse_state_t      state;
    logic              pending;    // Byte requested, not yet delivered
    logic [CNT_W-1:0]  opds_need;
    logic [CNT_W-1:0]  opds_idx;
    logic [TIME_W-1:0] tmr;        // Idle cycles since the last operand
    logic [CNT_W:0]    dec;
    logic              byte_in;
    logic              want_byte;

    // MSB flags a known opcode, low bits give the operand count
    function automatic logic [CNT_W:0] decode_opc(input logic [BYTE_W-1:0] b);
        case (b)
            INTERREGW, GLOBALREGW, JPEGREGW, DISPLAYREGW, SENSREGW:
                decode_opc = {1'b1, CNT_W'(2)};
            INTERREGR, GLOBALREGR, JPEGREGR, DISPLAYREGR, SENSREGR, GETMEAS:
                decode_opc = {1'b1, CNT_W'(1)};
            GETMEASNUM, RTMEAS:
                decode_opc = {1'b1, CNT_W'(0)};
            default:
                decode_opc = '0;  // NOP lands here too
        endcase
    endfunction

    assign dec       = decode_opc(data_byte);
    assign byte_in   = pending && data_ready;
    assign want_byte = data_valid && !pending;

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            pending   <= 1'b0;
            get_data  <= 1'b0;
            cmd_valid <= 1'b0;
            opds_need <= '0;
            opds_idx  <= '0;
            tmr       <= '0;
        end else begin
            get_data  <= 1'b0;
            cmd_valid <= 1'b0;
            case (state)
                IDLE: begin
                    pending <= 1'b0;  // Forget a request cut by a timeout
                    tmr     <= '0;
                    state   <= GET_OPC;
                end
                GET_OPC: begin
                    if (want_byte) begin
                        get_data <= 1'b1;
                        pending  <= 1'b1;
                    end else if (byte_in) begin
                        pending   <= 1'b0;
                        opds_idx  <= '0;
                        opds_need <= dec[CNT_W-1:0];
                        tmr       <= '0;
                        if (!dec[CNT_W]) begin
                            state <= IDLE;          // Unknown opcode, silent
                        end else if (dec[CNT_W-1:0] == '0) begin
                            cmd_valid <= 1'b1;
                            state     <= WAIT_ACK;
                        end else begin
                            state <= GET_OPDS;
                        end
                    end
                end
                GET_OPDS: begin
                    if (byte_in) begin
                        pending  <= 1'b0;
                        tmr      <= '0;
                        opds_idx <= opds_idx + 1'b1;
                        if (opds_idx == opds_need - 1'b1) begin
                            cmd_valid <= 1'b1;
                            state     <= WAIT_ACK;
                        end
                    end else if (tmr >= opds_time_count) begin
                        state <= IDLE;  // Drop the partial command
                    end else begin
                        tmr <= tmr + 1'b1;
                        if (want_byte) begin
                            get_data <= 1'b1;
                            pending  <= 1'b1;
                        end
                    end
                end
                WAIT_ACK: if (ack_done) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // Command fields, captured as the bytes arrive
    always_ff @(posedge clk) begin
        if (byte_in && state == GET_OPC) cmd.opcode <= opcode_t'(data_byte);
        if (byte_in && state == GET_OPDS) begin
            if (opds_idx == '0) cmd.addr <= data_byte;
            else                cmd.data <= data_byte;
        end
    end

endmodule

// ==== src/reg_access.sv ====
// Performs one register access per command on the special port or the bus
// Only the targeted port's matching response is accepted
// A missing response is reported as TIMEOUT after delay_time_count cycles
module reg_access
    import proc_cmd_pkg::*;
    import proc_reg_pkg::*;
#(
    parameter int TIME_W = 24
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cmd_t              cmd,
    input  logic              cmd_valid,
    input  logic [TIME_W-1:0] delay_time_count,
    output spec_req_t         spec_req,
    input  reg_rsp_t          spec_rsp,
    output bus_req_t          bus_req,
    input  reg_rsp_t          bus_rsp,
    output result_t           res,
    output logic              res_valid
);

    cmd_t              cur;       // Held for the whole access
    logic              strobe;
    logic              waiting;
    logic [TIME_W-1:0] dly;
    logic              to_spec;
    logic              is_read;
    logic [BLK_W-1:0]  blk;
    logic [REG_W-1:0]  reg_addr;
    reg_rsp_t          rsp;
    logic              hit;
    logic              expired;

    // ----------------------------------------
    // Opcode to port, direction and address
    // ----------------------------------------
    always_comb begin
        to_spec  = 1'b0;
        is_read  = 1'b1;
        blk      = B_GLOBAL;
        reg_addr = cur.addr;
        case (cur.opcode)
            INTERREGW:   begin to_spec = 1'b1; is_read = 1'b0; end
            INTERREGR:   to_spec = 1'b1;
            GLOBALREGW:  is_read = 1'b0;
            JPEGREGW:    begin blk = B_JPEG;    is_read = 1'b0; end
            JPEGREGR:    blk = B_JPEG;
            DISPLAYREGW: begin blk = B_DISPLAY; is_read = 1'b0; end
            DISPLAYREGR: blk = B_DISPLAY;
            SENSREGW:    begin blk = B_SENS;    is_read = 1'b0; end
            SENSREGR, GETMEAS: blk = B_SENS;
            GETMEASNUM:  begin blk = B_SENS; reg_addr = A_NMEAS;   end
            RTMEAS:      begin blk = B_SENS; reg_addr = A_GETMEAS; end
            default: ;  // GLOBALREGR keeps the defaults
        endcase
    end

    assign spec_req.write_en   = strobe && to_spec && !is_read;
    assign spec_req.read_en    = strobe && to_spec && is_read;
    assign spec_req.addr       = reg_addr;
    assign spec_req.write_data = cur.data;

    assign bus_req.write_en    = strobe && !to_spec && !is_read;
    assign bus_req.read_en     = strobe && !to_spec && is_read;
    assign bus_req.addr        = {blk, reg_addr};
    assign bus_req.write_data  = cur.data;

    assign rsp     = to_spec ? spec_rsp : bus_rsp;
    assign hit     = waiting && (is_read ? rsp.data_ready : rsp.write_done);
    assign expired = waiting && !hit && (dly >= delay_time_count);

    // ----------------------------------------
    // Strobe and wait control
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe    <= 1'b0;
            waiting   <= 1'b0;
            dly       <= '0;
            res_valid <= 1'b0;
        end else begin
            strobe    <= cmd_valid;
            res_valid <= hit || expired;
            if (cmd_valid) begin
                waiting <= 1'b1;
                dly     <= '0;        // Zero in the strobe cycle
            end else if (hit || expired) begin
                waiting <= 1'b0;
            end else if (waiting) begin
                dly <= dly + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) cur <= cmd;
        if (hit) begin
            if (is_read) res.kind <= READ_OK;
            else         res.kind <= WRITE_OK;
            res.read_data <= rsp.read_data;
        end else if (expired) begin
            res.kind      <= TIMEOUT;
            res.read_data <= '0;
        end
    end

endmodule

// ==== src/ack_tx.sv ====
// Sends the text acknowledgement of one result, one byte per free cycle
// tx_full is sampled in the cycle before each byte goes out
// A new result must not arrive before ack_done
module ack_tx
    import proc_cmd_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  result_t           res,
    input  logic              res_valid,
    input  logic              tx_full,
    output logic [BYTE_W-1:0] ack_byte,
    output logic              ack_valid,
    output logic              ack_done
);

    localparam int MSG_LEN   = 11;               // Longest message, READ+OK
    localparam int MSG_W     = MSG_LEN * BYTE_W;
    localparam int LEFT_W    = $clog2(MSG_LEN + 1);
    localparam int LEN_WRITE = 10;
    localparam int LEN_TMO   = 9;

    localparam logic [BYTE_W-1:0] CR = 8'h0D;
    localparam logic [BYTE_W-1:0] LF = 8'h0A;

    logic [MSG_W-1:0]  msg;   // Next byte sits in the top slot
    logic [LEFT_W-1:0] left;  // Bytes still to send
    logic              send;

    function automatic logic [LEFT_W-1:0] msg_len(input ack_kind_t kind);
        case (kind)
            READ_OK:  msg_len = LEFT_W'(MSG_LEN);
            WRITE_OK: msg_len = LEFT_W'(LEN_WRITE);
            default:  msg_len = LEFT_W'(LEN_TMO);
        endcase
    endfunction

    assign send = (left != '0) && !tx_full;

    // ----------------------------------------
    // Byte counter and strobes
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left      <= '0;
            ack_valid <= 1'b0;
            ack_done  <= 1'b0;
        end else begin
            ack_valid <= 1'b0;
            ack_done  <= ack_valid && (left == '0);  // Cycle after the last byte
            if (res_valid) begin
                left <= msg_len(res.kind);
            end else if (send) begin
                ack_valid <= 1'b1;
                left      <= left - 1'b1;
            end
        end
    end

    // Message text, left aligned and padded
    always_ff @(posedge clk) begin
        if (res_valid) begin
            case (res.kind)
                READ_OK:  msg <= {"READ+OK:", res.read_data, CR, LF};
                WRITE_OK: msg <= {"WRITE+OK", CR, LF, 8'h00};
                default:  msg <= {"TIMEOUT", CR, LF, 16'h0000};
            endcase
        end else if (send) begin
            ack_byte <= msg[MSG_W-1 -: BYTE_W];
            msg      <= msg << BYTE_W;
        end
    end

endmodule

// ==== src/proc_top.sv ====
// Command processor for the byte-serial external link
// Chain of parser, register access and acknowledgement transmitter
// Both timeout counts are TIME_W bits wide and must be held stable
module proc_top
    import proc_cmd_pkg::*;
    import proc_reg_pkg::*;
#(
    parameter int TIME_W = 24
) (
    input  logic              clk,
    input  logic              rst_n,
    // Receiver
    input  logic              data_valid,
    input  logic              data_ready,
    input  logic [BYTE_W-1:0] data_byte,
    output logic              get_data,
    // Transmitter
    input  logic              tx_full,
    output logic [BYTE_W-1:0] ack_byte,
    output logic              ack_valid,
    // Register ports
    output spec_req_t         spec_req,
    input  reg_rsp_t          spec_rsp,
    output bus_req_t          bus_req,
    input  reg_rsp_t          bus_rsp,
    // Timing configuration
    input  logic [TIME_W-1:0] opds_time_count,
    input  logic [TIME_W-1:0] delay_time_count
);

    cmd_t    cmd;
    logic    cmd_valid;
    result_t res;
    logic    res_valid;
    logic    ack_done;

    cmd_parser #(.TIME_W(TIME_W)) u_parser (
        .clk             (clk),
        .rst_n           (rst_n),
        .data_valid      (data_valid),
        .data_ready      (data_ready),
        .data_byte       (data_byte),
        .get_data        (get_data),
        .opds_time_count (opds_time_count),
        .ack_done        (ack_done),
        .cmd             (cmd),
        .cmd_valid       (cmd_valid)
    );

    reg_access #(.TIME_W(TIME_W)) u_access (
        .clk              (clk),
        .rst_n            (rst_n),
        .cmd              (cmd),
        .cmd_valid        (cmd_valid),
        .delay_time_count (delay_time_count),
        .spec_req         (spec_req),
        .spec_rsp         (spec_rsp),
        .bus_req          (bus_req),
        .bus_rsp          (bus_rsp),
        .res              (res),
        .res_valid        (res_valid)
    );

    ack_tx u_ack (
        .clk       (clk),
        .rst_n     (rst_n),
        .res       (res),
        .res_valid (res_valid),
        .tx_full   (tx_full),
        .ack_byte  (ack_byte),
        .ack_valid (ack_valid),
        .ack_done  (ack_done)
    );

endmodule

// ==== test/proc_asserts.sv ====
// Protocol checks bound into the processor top level
// Transmit back-pressure is judged on the cycle before each byte
module proc_asserts
    import proc_reg_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      get_data,
    input logic      tx_full,
    input logic      ack_valid,
    input spec_req_t spec_req,
    input bus_req_t  bus_req
);

    // ----------------------------------------
    // Transmit and receive handshakes
    // ----------------------------------------
    a_ack_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        ack_valid |-> !$past(tx_full))
        else $error("ack byte sent after a full cycle");

    a_get_single: assert property (@(posedge clk) disable iff (!rst_n)
        get_data |=> !get_data)
        else $error("get_data high for two cycles");

    // One direction and one port per strobe
    a_dir_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(spec_req.write_en && spec_req.read_en) && !(bus_req.write_en && bus_req.read_en))
        else $error("write and read strobes together");

    a_port_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !((spec_req.write_en || spec_req.read_en) && (bus_req.write_en || bus_req.read_en)))
        else $error("special and bus strobes together");

endmodule

bind proc_top proc_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .get_data  (get_data),
    .tx_full   (tx_full),
    .ack_valid (ack_valid),
    .spec_req  (spec_req),
    .bus_req   (bus_req)
);

// ==== test/tb_proc.sv ====
// Testbench for the command processor
// Receiver and register models answer after short random delays
// Only one command is sent at a time, as the processor expects
module tb_proc
    import proc_reg_pkg::*;
();

    localparam int TIME_W      = 24;
    localparam int OPDS_TO     = 30;
    localparam int DELAY_TO    = 20;
    localparam int NUM_CMDS    = 28;
    localparam int CMD_CYCLES  = 200;  // Worst case per command, with tx_full toggling
    localparam int SILENT_WAIT = OPDS_TO + 16;

    typedef logic [7:0] bytes_t[$];

    logic              clk = 1'b0;
    logic              rst_n;
    logic              data_valid, data_ready, get_data, tx_full, ack_valid;
    logic [7:0]        data_byte, ack_byte;
    spec_req_t         spec_req;
    bus_req_t          bus_req;
    reg_rsp_t          spec_rsp, bus_rsp;
    logic [TIME_W-1:0] opds_time_count, delay_time_count;

    logic [7:0]  spec_mem [256];
    logic [7:0]  bus_mem [1024];
    logic [7:0]  rx_q [$];
    logic [7:0]  exp_q [$];
    logic [31:0] lfsr_main, lfsr_rx, lfsr_reg, lfsr_tx;
    logic        muted, toggle_tx;
    int          strobe_cnt;
    logic        last_is_spec;
    logic        last_wr;
    logic [9:0]  last_addr;
    logic [7:0]  last_wdata;

    proc_top #(.TIME_W(TIME_W)) u_dut (.*);

    always #2 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = st[31] ^ st[21] ^ st[1] ^ st[0];
            st = {st[30:0], fb};
            r  = {r[30:0], fb};
        end
        return r;
    endfunction

    // ----------------------------------------
    // Reference model of the protocol
    // ----------------------------------------
    function automatic int num_opds(input logic [7:0] opc);
        case (opc)
            8'h01, 8'h03, 8'h05, 8'h07, 8'h09:        return 2;
            8'h02, 8'h04, 8'h06, 8'h08, 8'h0A, 8'h0C: return 1;
            8'h0B, 8'h0D:                             return 0;
            default:                                  return -1;
        endcase
    endfunction

    // {special port, read, 10-bit address}
    function automatic logic [11:0] target(input logic [7:0] opc, input logic [7:0] addr);
        case (opc)
            8'h01:   return {2'b10, 2'd0, addr};
            8'h02:   return {2'b11, 2'd0, addr};
            8'h03, 8'h05, 8'h07, 8'h09: return {2'b00, 2'((opc - 8'h03) >> 1), addr};
            8'h04, 8'h06, 8'h08, 8'h0A: return {2'b01, 2'((opc - 8'h04) >> 1), addr};
            8'h0B:   return {2'b01, 2'd3, 8'hF0};
            8'h0C:   return {2'b01, 2'd3, addr};
            8'h0D:   return {2'b01, 2'd3, 8'hF1};
            default: return '0;
        endcase
    endfunction

    function automatic bytes_t ref_ack(input logic [7:0] opc, input logic [7:0] addr,
                                       input int give, input logic mute,
                                       input logic [7:0] snap);
        bytes_t      r;
        string       s;
        logic [11:0] t;
        t = target(opc, addr);
        if (num_opds(opc) < 0 || give < num_opds(opc)) return r;  // Silent
        if (mute)       s = "TIMEOUT";
        else if (t[10]) s = "READ+OK:";
        else            s = "WRITE+OK";
        for (int i = 0; i < s.len(); i++) r.push_back(s[i]);
        if (!mute && t[10]) r.push_back(snap);
        r.push_back(8'h0D);
        r.push_back(8'h0A);
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // Sends one command and waits for its answer or for the parser to give up
    task automatic issue(input logic [7:0] opc, input logic [7:0] addr,
                         input logic [7:0] data, input int give);
        bytes_t      e;
        logic [11:0] t;
        logic [7:0]  snap;
        t    = target(opc, addr);
        snap = t[11] ? spec_mem[t[7:0]] : bus_mem[t[9:0]];
        e    = ref_ack(opc, addr, give, muted, snap);
        strobe_cnt = 0;
        foreach (e[i]) exp_q.push_back(e[i]);
        rx_q.push_back(opc);
        if (give > 0) rx_q.push_back(addr);
        if (give > 1) rx_q.push_back(data);
        data_valid = 1'b1;
        if (e.size() == 0) begin
            repeat (SILENT_WAIT) @(posedge clk);
            check("strobe_cnt", strobe_cnt, 0);
        end else begin
            while (exp_q.size() != 0) @(posedge clk);
            check("strobe_cnt", strobe_cnt, 1);
            check("port_is_spec", last_is_spec, t[11]);
            check("req_addr", last_addr, t[9:0]);
            check("req_write", last_wr, !t[10]);
            if (!t[10]) check("write_data", last_wdata, data);
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    // ----------------------------------------
    // Receiver model
    // ----------------------------------------
    always begin
        int n;
        @(posedge clk);
        if (rst_n && get_data) begin
            n = 1 + int'(take_bits(lfsr_rx, 2) % 3);
            repeat (n - 1) @(posedge clk);
            #1;
            if (rx_q.size() == 0) begin
                abort_run("byte requested with nothing waiting");
            end else begin
                data_ready = 1'b1;
                data_byte  = rx_q.pop_front();
                data_valid = rx_q.size() != 0;
                @(posedge clk);
                #1 data_ready = 1'b0;
            end
        end
    end

    // Register models for both ports, muted ones never answer
    always begin
        logic       is_spec, wr;
        logic [9:0] a;
        reg_rsp_t   r;
        int         n;
        @(posedge clk);
        is_spec = spec_req.write_en || spec_req.read_en;
        if (rst_n && (is_spec || bus_req.write_en || bus_req.read_en)) begin
            strobe_cnt++;
            last_is_spec = is_spec;
            a  = is_spec ? {2'b00, spec_req.addr} : bus_req.addr;
            wr = is_spec ? spec_req.write_en : bus_req.write_en;
            last_addr  = a;
            last_wr    = wr;
            last_wdata = is_spec ? spec_req.write_data : bus_req.write_data;
            if (!muted) begin
                if (wr && is_spec)  spec_mem[a[7:0]] = spec_req.write_data;
                if (wr && !is_spec) bus_mem[a]       = bus_req.write_data;
                r.write_done = wr;
                r.data_ready = !wr;
                r.read_data  = is_spec ? spec_mem[a[7:0]] : bus_mem[a];
                n = 1 + int'(take_bits(lfsr_reg, 2));
                repeat (n - 1) @(posedge clk);
                #1;
                if (is_spec) spec_rsp = r;
                else         bus_rsp  = r;
                @(posedge clk);
                #1;
                spec_rsp = '0;
                bus_rsp  = '0;
            end
        end
    end

    always begin
        logic [31:0] b;
        @(posedge clk);
        #1;
        b = toggle_tx ? take_bits(lfsr_tx, 1) : 32'd0;
        tx_full = b[0];
    end

    // Compare process
    always @(posedge clk) begin
        if (rst_n && ack_valid) begin
            if (exp_q.size() == 0) abort_run("ack byte arrived when none was expected");
            else check("ack_byte", ack_byte, exp_q.pop_front());
        end
    end

    initial begin
        #(NUM_CMDS * CMD_CYCLES * 4);
        abort_run("watchdog expired before the tests finished");
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [7:0]  a, d, opc;
        logic [31:0] r;
        lfsr_main = 32'hf0f0_6c00;
        lfsr_rx   = 32'hf0f0_6c00;
        lfsr_reg  = 32'hf0f0_6c00;
        lfsr_tx   = 32'hf0f0_6c00;
        rst_n = 1'b0;
        data_valid = 1'b0;
        data_ready = 1'b0;
        data_byte  = '0;
        tx_full    = 1'b0;
        spec_rsp   = '0;
        bus_rsp    = '0;
        opds_time_count  = TIME_W'(OPDS_TO);
        delay_time_count = TIME_W'(DELAY_TO);
        muted = 1'b0;
        toggle_tx = 1'b0;
        for (int i = 0; i < 256; i++) spec_mem[i] = 8'(i) ^ 8'h5A;
        for (int i = 0; i < 1024; i++) bus_mem[i] = 8'(i) ^ {4{2'(i >> 8)}} ^ 8'hC3;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        // Special port write then read
        a = 8'(take_bits(lfsr_main, 8));
        d = 8'(take_bits(lfsr_main, 8));
        issue(8'h01, a, d, 2);
        issue(8'h02, a, 8'h00, 1);
        // All four bus blocks
        for (int k = 0; k < 4; k++) begin
            a = 8'(take_bits(lfsr_main, 8));
            d = 8'(take_bits(lfsr_main, 8));
            issue(8'(8'h03 + 2 * k), a, d, 2);
            issue(8'(8'h04 + 2 * k), a, 8'h00, 1);
        end
        // Sensor measurements
        issue(8'h0B, 8'h00, 8'h00, 0);
        issue(8'h0D, 8'h00, 8'h00, 0);
        issue(8'h0C, a, 8'h00, 1);
        // No register answers
        muted = 1'b1;
        issue(8'h05, a, d, 2);
        issue(8'h02, a, 8'h00, 1);
        muted = 1'b0;
        // Invalid and truncated commands, then a good one
        issue(8'h00, 8'h00, 8'h00, 0);
        issue(8'h2F, 8'h00, 8'h00, 0);
        issue(8'h01, a, d, 1);
        issue(8'h0A, a, 8'h00, 0);
        issue(8'h02, a, 8'h00, 1);
        // Random commands under transmit back-pressure
        toggle_tx = 1'b1;
        for (int k = 0; k < 8; k++) begin
            r   = take_bits(lfsr_main, 8);
            opc = 8'(1 + r % 13);
            a   = 8'(take_bits(lfsr_main, 8));
            d   = 8'(take_bits(lfsr_main, 8));
            issue(opc, a, d, num_opds(opc));
        end
        toggle_tx = 1'b0;
        repeat (10) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("expected ack bytes never arrived");
        end
    end

endmodule

// ==== all.f ====
src/proc_cmd_pkg.sv
src/proc_reg_pkg.sv
src/cmd_parser.sv
src/reg_access.sv
src/ack_tx.sv
src/proc_top.sv
test/proc_asserts.sv
test/tb_proc.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_proc -f all.f -o sim_proc
./obj_dir/sim_proc > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "run ended without a pass result"
    exit 1
fi
exit 0
